//--- all.f
+incdir+test
rtl/decodePkg.sv
rtl/fetchBuffer.sv
rtl/mainDecoder.sv
rtl/aluDecoder.sv
rtl/decodeRegister.sv
rtl/decodeStage.sv
test/decodeStageTb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - rtl/decodePkg.sv
      - rtl/fetchBuffer.sv
      - rtl/mainDecoder.sv
      - rtl/aluDecoder.sv
      - rtl/decodeRegister.sv
      - rtl/decodeStage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/decodeStageTb.sv

//--- test/refDecode.svh
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

// defined SPECIAL functs and memory opcodes
logic [5:0] knownFunct [28] = '{
	6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0c, 6'h0d,
	6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h20, 6'h21,
	6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
};
logic [5:0] memOps [8] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};

function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [14:0] regs);
	return {6'h00, regs, regs[4:0], fn}; // fields rs rt rd with shamt copied from rd
endfunction

function automatic logic [31:0] iWord(input logic [5:0] op, input logic [14:0] regs,
		input logic [15:0] imm);
	return {op, regs[9:0], imm};
endfunction

// 0-3 plain branches, 4-5 jumps, 6 regimm, 7 regimm with any rt
function automatic logic [31:0] branchWord(input logic [2:0] sel, input logic [14:0] regs,
		input logic [15:0] imm);
	case (sel)
		3'd4: return iWord(6'h02, regs, imm);
		3'd5: return iWord(6'h03, regs, imm);
		3'd6: return {6'h01, regs[4:0], imm[1], 3'b000, imm[0], imm};
		3'd7: return {6'h01, regs[4:0], regs[9:5], imm};
		default: return iWord(6'h04 + {3'b000, sel}, regs, imm);
	endcase
endfunction

function automatic logic [31:0] cop0Word(input logic [1:0] sel, input logic [14:0] regs,
		input logic exact);
	case (sel)
		2'd0: return {6'h10, 5'h00, regs[9:0], 11'h000};
		2'd1: return {6'h10, 5'h04, regs[9:0], 11'h000};
		2'd2: return exact ? 32'h4200_0018 : {6'h10, 5'h10, regs, 6'h18};
		default: return {6'h10, regs[4:0], regs, 6'h00};
	endcase
endfunction

function automatic logic isKnownFunct(input logic [5:0] fn);
	foreach (knownFunct[i]) begin
		if (knownFunct[i] == fn) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

function automatic aluOpE rTypeOp(input logic [5:0] fn);
	case (fn)
		FN_ADD: return ALU_ADD;
		FN_ADDU: return ALU_ADDU;
		FN_SUB: return ALU_SUB;
		FN_SUBU: return ALU_SUBU;
		FN_AND: return ALU_AND;
		FN_OR: return ALU_OR;
		FN_XOR: return ALU_XOR;
		FN_NOR: return ALU_NOR;
		FN_SLT: return ALU_SLT;
		FN_SLTU: return ALU_SLTU;
		FN_SLL, FN_SLLV: return ALU_SLL;
		FN_SRL, FN_SRLV: return ALU_SRL;
		FN_SRA, FN_SRAV: return ALU_SRA;
		FN_MULT: return ALU_MULT;
		FN_MULTU: return ALU_MULTU;
		FN_DIV: return ALU_DIV;
		FN_DIVU: return ALU_DIVU;
		default: return ALU_NOP;
	endcase
endfunction

// expected ID/EX contents for one fetched word
function automatic decodedT expectDecode(input fetchT f);
	decodedT d;
	logic [5:0] op;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [5:0] fn;
	op = f.instr[31:26];
	rs = f.instr[25:21];
	rt = f.instr[20:16];
	fn = f.instr[5:0];
	d = '0;
	d.pc = f.pc;
	d.instr = f.instr;
	d.ctrl.aluClass = CL_NONE;
	d.aluOp = ALU_NOP;
	d.exc = EXC_NONE;
	d.ctrl.signExt = op[5:2] != 4'b0011; // logical immediates and LUI are 0x0c to 0x0f
	case (op)
		OP_SPECIAL: begin
			if (!isKnownFunct(fn)) begin
				d.exc = EXC_RESERVED;
			end else begin
				d.ctrl.aluClass = CL_R_TYPE;
				d.aluOp = rTypeOp(fn);
				d.ctrl.hiloWrite = fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO};
				d.ctrl.hiloToReg = fn inside {FN_MFHI, FN_MFLO};
				d.ctrl.regWrite = !(fn inside {FN_JR, FN_SYSCALL, FN_BREAK}) && !d.ctrl.hiloWrite;
				d.ctrl.regDst = (fn == FN_JALR) ? DST_RA : DST_RD;
				if (fn == FN_SYSCALL) begin
					d.exc = EXC_SYSCALL;
				end else if (fn == FN_BREAK) begin
					d.exc = EXC_BREAK;
				end
			end
		end
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
			d.ctrl.regWrite = 1'b1;
			d.ctrl.regDst = DST_RT;
			d.ctrl.aluSrcImm = 1'b1;
			d.ctrl.aluClass = aluClassE'({1'b0, op[2:0]} + 4'd1); // classes follow opcode order
			case (op)
				OP_ADDI: d.aluOp = ALU_ADD;
				OP_ADDIU: d.aluOp = ALU_ADDU;
				OP_SLTI: d.aluOp = ALU_SLT;
				OP_SLTIU: d.aluOp = ALU_SLTU;
				OP_ANDI: d.aluOp = ALU_AND;
				OP_ORI: d.aluOp = ALU_OR;
				OP_XORI: d.aluOp = ALU_XOR;
				default: d.aluOp = ALU_LUI;
			endcase
		end
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
			d.ctrl.aluSrcImm = 1'b1;
			d.ctrl.aluClass = CL_MEM;
			d.aluOp = ALU_ADDU;
			d.ctrl.memWrite = op[3]; // stores have bit 3 set
			if (!op[3]) begin
				d.ctrl.regWrite = 1'b1;
				d.ctrl.regDst = DST_RT;
				d.ctrl.memRead = 1'b1;
				d.ctrl.memToReg = 1'b1;
			end
		end
		OP_BEQ: d.ctrl.branch = BR_EQ;
		OP_BNE: d.ctrl.branch = BR_NE;
		OP_BLEZ: d.ctrl.branch = BR_LEZ;
		OP_BGTZ: d.ctrl.branch = BR_GTZ;
		OP_J: d.ctrl.branch = BR_NONE;
		OP_JAL: begin
			d.ctrl.regWrite = 1'b1;
			d.ctrl.regDst = DST_RA;
		end
		OP_REGIMM: begin
			if (rt[3:1] != 3'b000) begin
				d.exc = EXC_RESERVED;
			end else begin
				d.ctrl.branch = rt[0] ? BR_GEZ : BR_LTZ;
				d.ctrl.regWrite = rt[4]; // link forms
				d.ctrl.regDst = rt[4] ? DST_RA : DST_RD;
			end
		end
		OP_COP0: begin
			if (rs == 5'h00 || rs == 5'h04) begin
				d.ctrl.aluClass = CL_CP0;
				d.aluOp = ALU_PASS;
				d.ctrl.cp0Write = rs[2];
				d.ctrl.cp0ToReg = !rs[2];
				d.ctrl.isMfc0 = !rs[2];
				d.ctrl.regWrite = !rs[2];
				d.ctrl.regDst = rs[2] ? DST_RD : DST_RT;
			end else if (f.instr == 32'h4200_0018) begin
				d.exc = EXC_ERET;
			end else begin
				d.exc = EXC_RESERVED;
			end
		end
		default: d.exc = EXC_RESERVED;
	endcase
	if (d.exc != EXC_NONE) begin
		d.ctrl.regWrite = 1'b0;
		d.ctrl.memWrite = 1'b0;
		d.ctrl.hiloWrite = 1'b0;
		d.ctrl.cp0Write = 1'b0;
	end
	return d;
endfunction

function automatic string behaviorName(input decodedT d);
	if (d.exc != EXC_NONE || d.ctrl.aluClass == CL_CP0) begin
		return "traps_cp0";
	end else if (d.ctrl.branch != BR_NONE || d.instr[31:27] == 5'b00001 ||
			(d.instr[31:26] == 6'h00 && d.instr[5:1] == 5'b00100)) begin
		return "branch_jump";
	end else if (d.ctrl.aluClass == CL_R_TYPE) begin
		return "rtype_hilo";
	end
	return "imm_mem";
endfunction

`endif

//--- test/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb import decodePkg::*; ();

	localparam int clkPeriod = 8;
	localparam int resetCycles = 16;
	localparam int fastCount = 60; // outReady held high, no flush
	localparam int totalCount = 400;

	logic clk;
	logic reset;
	logic flush;
	logic inValid;
	fetchT inFetch;
	logic inReady;
	logic outValid;
	decodedT outDecoded;
	logic outReady;

	logic [15:0] lfsrState = 16'd11556;
	fetchT expectQ[$];
	int acceptQ[$]; // cycle of each accepted word
	int cycle = 0;
	int lastLowReady = 0;
	int issued = 0;
	logic stalled = 1'b0;
	logic flushed = 1'b0;
	logic wasReset = 1'b1;
	decodedT heldDecoded;

	`include "refDecode.svh"

	decodeStage i_dut (.*);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], nextBit()};
		end
		return v;
	endfunction

	function automatic logic [31:0] randomInstr();
		logic [2:0] kind;
		logic [14:0] regs;
		logic [15:0] imm;
		kind = randBits(3);
		regs = randBits(15);
		imm = randBits(16);
		case (kind)
			3'd0, 3'd1: return rWord(knownFunct[randBits(5) % 28], regs);
			3'd2: return iWord(6'h08 + 6'(randBits(3)), regs, imm);
			3'd3: return iWord(memOps[randBits(3)], regs, imm);
			3'd4: return branchWord(randBits(3), regs, imm);
			3'd5: return cop0Word(randBits(2), regs, randBits(1));
			3'd6: return rWord(randBits(1) ? 6'h0d : 6'h0c, regs);
			default: return randBits(32); // mostly undefined encodings
		endcase
	endfunction

	task automatic reportMismatch(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("[ERROR] %s: expected %0h actual %0h", name, expected, actual);
		$display("Test FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic reportFailure(input string what);
		$display("[ERROR] %s", what);
		$display("Test FAILED");
		$fatal(1, "stopping at first error");
	endtask

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#((resetCycles + 20 * totalCount) * clkPeriod);
		reportFailure("timeout, the stage stopped delivering instructions");
	end

	initial begin
		logic [31:0] pcNext;
		logic fast;
		pcNext = 32'hbfc0_0000;
		reset = 1'b1;
		flush = 1'b0;
		inValid = 1'b0;
		inFetch = '0;
		outReady = 1'b0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
		while (issued < totalCount) begin
			@(posedge clk);
			fast = issued < fastCount;
			// previous offer taken or flushed away
			if (!inValid || inReady || flush) begin
				if (fast || randBits(2) != 2'd0) begin
					inValid <= 1'b1;
					inFetch.instr <= randomInstr();
					inFetch.pc <= pcNext;
					pcNext = pcNext + 4;
					issued++;
				end else begin
					inValid <= 1'b0;
				end
			end
			outReady <= fast || randBits(2) != 2'd0;
			flush <= !fast && randBits(5) == 5'd0;
		end
		outReady <= 1'b1;
		flush <= 1'b0;
		do begin
			@(posedge clk);
		end while (inValid && !inReady);
		inValid <= 1'b0;
		@(posedge clk);
		while (expectQ.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (!outValid) begin
			$display("Test OK");
			$finish;
		end else begin
			reportFailure("the stage still held instructions after draining");
		end
	end

	// scoreboard samples on the edge before the driver's updates land
	always @(posedge clk) begin
		fetchT head;
		int acceptedAt;
		decodedT expected;
		cycle++;
		if (!reset) begin
			if (wasReset || flushed) begin
				assert (!outValid) else reportMismatch("reset_flush", 0, outValid);
			end
			// ready drops only with both slots full and the output stalled
			assert (inReady == (outReady || expectQ.size() < 2))
				else reportMismatch("handshake_ready", outReady || expectQ.size() < 2, inReady);
			if (stalled) begin
				assert (outValid) else reportFailure("outValid dropped while the output was stalled");
				assert (outDecoded == heldDecoded)
					else reportMismatch("handshake_stall", heldDecoded, outDecoded);
			end
			if (outValid && outReady) begin
				assert (expectQ.size() != 0)
					else reportFailure("an output appeared with no instruction outstanding");
				head = expectQ.pop_front();
				acceptedAt = acceptQ.pop_front();
				expected = expectDecode(head);
				assert (outDecoded == expected)
					else reportMismatch(behaviorName(expected), expected, outDecoded);
				if (acceptedAt > lastLowReady) begin
					assert (cycle - acceptedAt == 2)
						else reportMismatch("handshake_latency", 2, cycle - acceptedAt);
				end
			end
			if (flush) begin
				expectQ.delete(); // both slots emptied
				acceptQ.delete();
			end else if (inValid && inReady) begin
				expectQ.push_back(inFetch);
				acceptQ.push_back(cycle);
			end
		end
		if (!outReady) begin
			lastLowReady = cycle;
		end
		stalled = outValid && !outReady && !flush && !reset;
		flushed = flush && !reset;
		wasReset = reset;
		heldDecoded = outDecoded;
	end

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic flush,

	input  logic inValid,
	input  fetchT inFetch,
	output logic inReady,

	output logic outValid,
	output decodedT outDecoded,
	input  logic outReady
);

	logic bufValid;
	fetchT bufFetch;
	logic regReady;
	ctrlT ctrl;
	trapT trap;
	aluOpE aluOp;

	fetchBuffer i_fetch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.inValid(inValid),
		.inFetch(inFetch),
		.inReady(inReady),
		.bufValid(bufValid),
		.bufFetch(bufFetch),
		.regReady(regReady)
	);

	mainDecoder i_main (
		.instr(bufFetch.instr),
		.ctrl(ctrl),
		.trap(trap)
	);

	// funct field straight from the buffered word
	aluDecoder i_alu (
		.aluClass(ctrl.aluClass),
		.funct(functE'(bufFetch.instr[5:0])),
		.aluOp(aluOp)
	);

	decodeRegister i_out (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.bufValid(bufValid),
		.bufFetch(bufFetch),
		.ctrl(ctrl),
		.aluOp(aluOp),
		.trap(trap),
		.regReady(regReady),
		.outValid(outValid),
		.outDecoded(outDecoded),
		.outReady(outReady)
	);

endmodule

//--- rtl/decodeRegister.sv
`timescale 1ns/1ps

module decodeRegister import decodePkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic flush,

	input  logic bufValid,
	input  fetchT bufFetch,
	input  ctrlT ctrl,
	input  aluOpE aluOp,
	input  trapT trap,
	output logic regReady,

	output logic outValid,
	output decodedT outDecoded,
	input  logic outReady
);

	excE exc;
	decodedT nextDecoded;

	assign regReady = outReady || !outValid;

	always_comb begin
		if (trap.syscall) begin
			exc = EXC_SYSCALL;
		end else if (trap.brk) begin
			exc = EXC_BREAK;
		end else if (trap.eret) begin
			exc = EXC_ERET;
		end else if (trap.reserved) begin
			exc = EXC_RESERVED;
		end else begin
			exc = EXC_NONE;
		end

		nextDecoded.pc = bufFetch.pc;
		nextDecoded.instr = bufFetch.instr;
		nextDecoded.ctrl = ctrl;
		nextDecoded.aluOp = aluOp;
		nextDecoded.exc = exc;
		// a trapping instruction must not touch architectural state
		if (exc != EXC_NONE) begin
			nextDecoded.ctrl.regWrite = 1'b0;
			nextDecoded.ctrl.memWrite = 1'b0;
			nextDecoded.ctrl.hiloWrite = 1'b0;
			nextDecoded.ctrl.cp0Write = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			outValid <= 1'b0;
		end else if (regReady) begin
			outValid <= bufValid;
		end
	end

	always_ff @(posedge clk) begin
		if (bufValid && regReady) begin
			outDecoded <= nextDecoded; // held while stalled
		end
	end

endmodule

//--- rtl/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder import decodePkg::*; (
	input  aluClassE aluClass,
	input  functE funct,
	output aluOpE aluOp
);

	always_comb begin
		aluOp = ALU_NOP;
		case (aluClass)
			CL_R_TYPE: begin
				case (funct)
					FN_ADD: aluOp = ALU_ADD;
					FN_ADDU: aluOp = ALU_ADDU;
					FN_SUB: aluOp = ALU_SUB;
					FN_SUBU: aluOp = ALU_SUBU;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_XOR: aluOp = ALU_XOR;
					FN_NOR: aluOp = ALU_NOR;
					FN_SLT: aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					FN_SLL, FN_SLLV: aluOp = ALU_SLL; // shamt or rs picks the amount
					FN_SRL, FN_SRLV: aluOp = ALU_SRL;
					FN_SRA, FN_SRAV: aluOp = ALU_SRA;
					FN_MULT: aluOp = ALU_MULT;
					FN_MULTU: aluOp = ALU_MULTU;
					FN_DIV: aluOp = ALU_DIV;
					FN_DIVU: aluOp = ALU_DIVU;
					default: aluOp = ALU_NOP;
				endcase
			end
			CL_ADD_IMM: aluOp = ALU_ADD;
			CL_ADDU_IMM: aluOp = ALU_ADDU;
			CL_SLT_IMM: aluOp = ALU_SLT;
			CL_SLTU_IMM: aluOp = ALU_SLTU;
			CL_AND_IMM: aluOp = ALU_AND;
			CL_OR_IMM: aluOp = ALU_OR;
			CL_XOR_IMM: aluOp = ALU_XOR;
			CL_LUI: aluOp = ALU_LUI;
			CL_MEM: aluOp = ALU_ADDU; // base plus offset
			CL_CP0: aluOp = ALU_PASS;
			default: aluOp = ALU_NOP;
		endcase
	end

endmodule

//--- rtl/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder import decodePkg::*; (
	input  logic [dataWidth-1:0] instr,
	output ctrlT ctrl,
	output trapT trap
);

	opcodeE op;
	cop0E rs;
	regimmE rt;
	functE funct;

	assign op = opcodeE'(instr[31:26]);
	assign rs = cop0E'(instr[25:21]);
	assign rt = regimmE'(instr[20:16]);
	assign funct = functE'(instr[5:0]);

	always_comb begin
		ctrl = '0;
		ctrl.aluClass = CL_NONE;
		ctrl.signExt = !(op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
		trap = '0;

		case (op)
			OP_SPECIAL: begin
				ctrl.aluClass = CL_R_TYPE;
				case (funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA,
					FN_SLLV, FN_SRLV, FN_SRAV: begin
						ctrl.regWrite = 1'b1;
					end
					FN_MFHI, FN_MFLO: begin
						ctrl.regWrite = 1'b1;
						ctrl.hiloToReg = 1'b1;
					end
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO: begin
						ctrl.hiloWrite = 1'b1;
					end
					FN_JR: ctrl.regWrite = 1'b0; // jump only
					FN_JALR: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst = DST_RA;
					end
					FN_SYSCALL: trap.syscall = 1'b1;
					FN_BREAK: trap.brk = 1'b1;
					default: begin
						trap.reserved = 1'b1;
						ctrl.aluClass = CL_NONE;
					end
				endcase
			end

			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = DST_RT;
				ctrl.aluSrcImm = 1'b1;
				case (op)
					OP_ADDI: ctrl.aluClass = CL_ADD_IMM;
					OP_ADDIU: ctrl.aluClass = CL_ADDU_IMM;
					OP_SLTI: ctrl.aluClass = CL_SLT_IMM;
					OP_SLTIU: ctrl.aluClass = CL_SLTU_IMM;
					OP_ANDI: ctrl.aluClass = CL_AND_IMM;
					OP_ORI: ctrl.aluClass = CL_OR_IMM;
					OP_XORI: ctrl.aluClass = CL_XOR_IMM;
					default: ctrl.aluClass = CL_LUI;
				endcase
			end

			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = DST_RT;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluClass = CL_MEM;
			end
			OP_SB, OP_SH, OP_SW: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluClass = CL_MEM; // address add
			end

			OP_BEQ: ctrl.branch = BR_EQ;
			OP_BNE: ctrl.branch = BR_NE;
			OP_BLEZ: ctrl.branch = BR_LEZ;
			OP_BGTZ: ctrl.branch = BR_GTZ;
			OP_REGIMM: begin
				case (rt)
					RI_BLTZ: ctrl.branch = BR_LTZ;
					RI_BGEZ: ctrl.branch = BR_GEZ;
					RI_BLTZAL, RI_BGEZAL: begin
						ctrl.branch = (rt == RI_BLTZAL) ? BR_LTZ : BR_GEZ;
						ctrl.regWrite = 1'b1;
						ctrl.regDst = DST_RA;
					end
					default: trap.reserved = 1'b1;
				endcase
			end

			OP_J: ctrl.regWrite = 1'b0;
			OP_JAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = DST_RA; // link to r31
			end

			OP_COP0: begin
				case (rs)
					C0_MF: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst = DST_RT;
						ctrl.cp0ToReg = 1'b1;
						ctrl.isMfc0 = 1'b1;
						ctrl.aluClass = CL_CP0;
					end
					C0_MT: begin
						ctrl.cp0Write = 1'b1;
						ctrl.aluClass = CL_CP0;
					end
					C0_CO: begin
						// only eret is implemented among the co forms
						if (instr[25:0] == eretLow) begin
							trap.eret = 1'b1;
						end else begin
							trap.reserved = 1'b1;
						end
					end
					default: trap.reserved = 1'b1;
				endcase
			end

			default: trap.reserved = 1'b1;
		endcase
	end

endmodule

//--- rtl/fetchBuffer.sv
`timescale 1ns/1ps

module fetchBuffer import decodePkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic flush,

	input  logic inValid,
	input  fetchT inFetch,
	output logic inReady,

	output logic bufValid,
	output fetchT bufFetch,
	input  logic regReady
);

	logic load;

	// slot is free when empty or handed on this cycle
	assign inReady = regReady || !bufValid;
	assign load = inValid && inReady;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			bufValid <= 1'b0;
		end else if (inReady) begin
			bufValid <= inValid; // refill or go empty
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			bufFetch <= inFetch;
		end
	end

endmodule

//--- rtl/decodePkg.sv
package decodePkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam logic [25:0] eretLow = 26'h200_0018; // co bit plus funct 0x18

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J = 6'h02, OP_JAL = 6'h03,
		OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ = 6'h07,
		OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI = 6'h0c, OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f,
		OP_COP0 = 6'h10,
		OP_LB = 6'h20, OP_LH = 6'h21, OP_LW = 6'h23, OP_LBU = 6'h24, OP_LHU = 6'h25,
		OP_SB = 6'h28, OP_SH = 6'h29, OP_SW = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03,
		FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
		FN_JR = 6'h08, FN_JALR = 6'h09, FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
		FN_MFHI = 6'h10, FN_MTHI = 6'h11, FN_MFLO = 6'h12, FN_MTLO = 6'h13,
		FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV = 6'h1a, FN_DIVU = 6'h1b,
		FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
		FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_NOR = 6'h27,
		FN_SLT = 6'h2a, FN_SLTU = 6'h2b
	} functE;

	// rt field of REGIMM
	typedef enum logic [regAddrWidth-1:0] {
		RI_BLTZ = 5'h00, RI_BGEZ = 5'h01, RI_BLTZAL = 5'h10, RI_BGEZAL = 5'h11
	} regimmE;

	// rs field of COP0
	typedef enum logic [regAddrWidth-1:0] {
		C0_MF = 5'h00, C0_MT = 5'h04, C0_CO = 5'h10
	} cop0E;

	typedef enum logic [3:0] {
		CL_R_TYPE, CL_ADD_IMM, CL_ADDU_IMM, CL_SLT_IMM, CL_SLTU_IMM, CL_AND_IMM,
		CL_OR_IMM, CL_XOR_IMM, CL_LUI, CL_MEM, CL_CP0, CL_NONE
	} aluClassE;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
		ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU, ALU_PASS, ALU_NOP
	} aluOpE;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} branchE;

	typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} regDstE;

	// listed in priority order after none
	typedef enum logic [2:0] {
		EXC_NONE, EXC_SYSCALL, EXC_BREAK, EXC_ERET, EXC_RESERVED
	} excE;

	typedef struct packed {
		logic regWrite;
		regDstE regDst;
		logic aluSrcImm;
		logic signExt;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic hiloWrite;
		logic hiloToReg;
		logic cp0Write;
		logic cp0ToReg;
		logic isMfc0;
		branchE branch;
		aluClassE aluClass;
	} ctrlT;

	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] pc;
	} fetchT;

	typedef struct packed {
		logic syscall;
		logic brk;
		logic eret;
		logic reserved;
	} trapT;

	typedef struct packed {
		logic [dataWidth-1:0] pc;
		logic [dataWidth-1:0] instr;
		ctrlT ctrl;
		aluOpE aluOp;
		excE exc;
	} decodedT;

endpackage
